/* hdl/ctu_cken_pkg.sv */
// Clock-enable unit numbering and default levels, imported by the sequencer, collector and top
package ctu_cken_pkg;

  // Units under sequencer control
  localparam int unsigned num_unit = 9;

  // Bit position of each unit in every enable vector
  // Order is also the turn-on order after a start
  typedef enum logic [3:0] {
    dram02 = 4'd0,
    dram13 = 4'd1,
    efc    = 4'd2,
    iob    = 4'd3,
    jbi    = 4'd4,
    jbusl  = 4'd5,  // Always-running
    jbusr  = 4'd6,  // Always-running
    misc   = 4'd7,  // Always-running
    dbg    = 4'd8   // Always-running
  } cken_unit_e;

  // One enable bit per unit
  typedef logic [num_unit-1:0] cken_vec_t;

  // Level each unit holds while the JBus clock is not started
  // Always-running units idle on, the rest idle off
  localparam cken_vec_t cken_default_on = cken_vec_t'(
    (1 << jbusl) |
    (1 << jbusr) |
    (1 << misc)  |
    (1 << dbg)
  );

endpackage

/* hdl/ctu_trig_pkg.sv */
// Trigger source numbering and status vector type, imported by the collector and top
package ctu_trig_pkg;

  // Units that can raise a trigger toward the CTU
  localparam int unsigned num_trig = 5;

  // Bit position of each source in the trigger vectors
  typedef enum logic [2:0] {
    jbi    = 3'd0,
    iob    = 3'd1,
    iob_l2 = 3'd2,  // L2 trigger via IOB
    dram02 = 3'd3,
    dram13 = 3'd4
  } trig_src_e;

  // One bit per trigger source
  // Used for raw, retimed and sticky vectors
  typedef logic [num_trig-1:0] trig_vec_t;

endpackage

/* hdl/ctu_cken_seq.sv */
// Start/stop FSM that raises the unit pre-enables one by one, stagger cycles apart
module ctu_cken_seq
  import ctu_cken_pkg::*;
#(
  parameter int unsigned stagger = 4  // Cycles between turn-ons, 1 or more
) (
  input  logic      jbus_clk,
  input  logic      rst,
  input  logic      start,      // Pulse
  input  logic      stop,       // Pulse, wins over start
  output logic      start_clk,  // Clock started flag
  output cken_vec_t cken_pre    // Pre-enables toward the slices
);

  // Counter value at which the last unit gets its turn
  localparam int unsigned last_slot = (num_unit - 1) * stagger;
  localparam int unsigned cnt_w     = $clog2(last_slot + 1);

  logic [cnt_w-1:0] slot_cnt;  // Cycles since start, saturating
  logic             cnt_sat;   // Last slot reached
  cken_vec_t        slot_hit;  // Unit whose slot is now

  assign cnt_sat = (slot_cnt == cnt_w'(last_slot));

  // Unit k is due when the counter hits k * stagger
  always_comb begin
    for (int k = 0; k < num_unit; k++) begin
      slot_hit[k] = (slot_cnt == cnt_w'(k * stagger));
    end
  end

  // Started flag
  always_ff @(posedge jbus_clk) begin
    if (rst) begin
      start_clk <= 1'b0;
    end else if (stop) begin
      start_clk <= 1'b0;  // Stop has priority
    end else if (start) begin
      start_clk <= 1'b1;  // Repeat start is harmless
    end
  end

  // Turn-on counter
  always_ff @(posedge jbus_clk) begin
    if (rst || stop) begin
      slot_cnt <= '0;
    end else if (!start_clk) begin
      slot_cnt <= '0;  // Idle, wait at slot 0
    end else if (!cnt_sat) begin
      slot_cnt <= slot_cnt + 1'b1;
    end
  end

  // Pre-enables accumulate, each one set in its own slot
  always_ff @(posedge jbus_clk) begin
    if (rst) begin
      cken_pre <= '0;
    end else if (stop) begin
      cken_pre <= '0;  // All units drop together
    end else if (start_clk) begin
      cken_pre <= cken_pre | slot_hit;
    end
  end

endmodule

/* hdl/ctu_cken_sync_slice.sv */
// One unit's JBus retiming flop, holding the unit default until the clock is started
module ctu_cken_sync_slice #(
  parameter bit default_on = 1'b0  // Idle level of this unit
) (
  input  logic jbus_clk,
  input  logic rst,
  input  logic start_clk,  // From sequencer
  input  logic cken_pre,   // This unit's pre-enable
  output logic cken        // Retimed enable
);

  logic cken_nxt;

  // Not started means the default level
  // Off-type units load 0 and always-running units load 1
  assign cken_nxt = start_clk ? cken_pre : default_on;

  // Reset also parks the flop at the default
  always_ff @(posedge jbus_clk) begin
    if (rst) begin
      cken <= default_on;
    end else begin
      cken <= cken_nxt;  // One cycle behind the pre-enable
    end
  end

endmodule

/* hdl/ctu_trig_collect.sv */
// Gathers the retimed enables and retimes the unit triggers with edge and sticky status
module ctu_trig_collect
  import ctu_cken_pkg::*,
         ctu_trig_pkg::*;
(
  input  logic      jbus_clk,
  input  logic      rst,
  input  cken_vec_t cken_sync,    // Slice outputs
  input  trig_vec_t trig,         // Raw trigger levels
  input  logic      trig_clr,     // Clears sticky status
  output cken_vec_t cken,
  output logic      cken_all_on,  // Every unit enabled
  output trig_vec_t trig_jl,      // Retimed triggers
  output logic      trig_event,   // Any rising trigger
  output trig_vec_t trig_status   // Sticky rising edges
);

  trig_vec_t trig_prev;  // trig_jl one cycle back
  trig_vec_t trig_rise;  // 0 to 1 transitions

  // Slices already registered, no further stage
  assign cken = cken_sync;

  // All-on flag lags the last rising enable by one cycle
  always_ff @(posedge jbus_clk) begin
    if (rst) begin
      cken_all_on <= 1'b0;
    end else begin
      cken_all_on <= &cken_sync;
    end
  end

  // Single retiming stage, plus history for edge detect
  always_ff @(posedge jbus_clk) begin
    if (rst) begin
      trig_jl   <= '0;
      trig_prev <= '0;
    end else begin
      trig_jl   <= trig;
      trig_prev <= trig_jl;
    end
  end

  assign trig_rise = trig_jl & ~trig_prev;

  // Event is one cycle wide since trig_prev catches up next edge
  always_ff @(posedge jbus_clk) begin
    if (rst) begin
      trig_event <= 1'b0;
    end else begin
      trig_event <= |trig_rise;
    end
  end

  // Sticky status
  // A rise in the clear cycle still lands
  always_ff @(posedge jbus_clk) begin
    if (rst) begin
      trig_status <= '0;
    end else if (trig_clr) begin
      trig_status <= trig_rise;
    end else begin
      trig_status <= trig_status | trig_rise;
    end
  end

endmodule

/* hdl/ctu_clsp_top.sv */
// JBus clock-enable sequencer top, ties the sequencer, per-unit slices and collector together
module ctu_clsp_top
  import ctu_cken_pkg::*,
         ctu_trig_pkg::*;
#(
  parameter int unsigned stagger = 4  // Cycles between unit turn-ons
) (
  input  logic      jbus_clk,
  input  logic      rst,
  input  logic      start,        // Pulse, start sequence
  input  logic      stop,         // Pulse, all units to default
  input  trig_vec_t trig,         // Unit trigger levels
  input  logic      trig_clr,     // Pulse, clear sticky status
  output cken_vec_t cken,         // Per-unit enables
  output logic      cken_all_on,
  output trig_vec_t trig_jl,
  output logic      trig_event,
  output trig_vec_t trig_status
);

  logic      start_clk;  // Sequencer started
  cken_vec_t cken_pre;   // Staggered pre-enables
  cken_vec_t cken_sync;  // Retimed enables

  // Start/stop control
  ctu_cken_seq #(
    .stagger   (stagger)
  ) u_cken_seq (
    .jbus_clk  (jbus_clk),
    .rst       (rst),
    .start     (start),
    .stop      (stop),
    .start_clk (start_clk),
    .cken_pre  (cken_pre)
  );

  // One retiming slice per unit
  // Default level comes from the unit table
  for (genvar k = 0; k < num_unit; k++) begin : g_slice
    ctu_cken_sync_slice #(
      .default_on (cken_default_on[k])
    ) u_slice (
      .jbus_clk   (jbus_clk),
      .rst        (rst),
      .start_clk  (start_clk),
      .cken_pre   (cken_pre[k]),
      .cken       (cken_sync[k])
    );
  end

  // Enable fan-in and trigger handling
  ctu_trig_collect u_trig_collect (
    .jbus_clk    (jbus_clk),
    .rst         (rst),
    .cken_sync   (cken_sync),
    .trig        (trig),
    .trig_clr    (trig_clr),
    .cken        (cken),
    .cken_all_on (cken_all_on),
    .trig_jl     (trig_jl),
    .trig_event  (trig_event),
    .trig_status (trig_status)
  );

endmodule

/* verif/ctu_clsp_assert.sv */
// Concurrent checks on the clock-enable sequencer top, attached to ctu_clsp_top with bind
module ctu_clsp_assert
  import ctu_cken_pkg::*;
(
  input logic      jbus_clk,
  input logic      rst,
  input logic      start_clk,    // Sequencer started flag, internal to the top
  input cken_vec_t cken,
  input logic      trig_event
);

  int unsigned fail_cnt = 0;  // Failed assertions so far

  // Event strobe is one cycle wide
  a_event_pulse: assert property (
    @(posedge jbus_clk) disable iff (rst)
    trig_event |=> !trig_event
  ) else begin
    fail_cnt++;
    $error("trig_event stayed high for two cycles");
  end

  // Idle-off units only come up through a started sequencer
  // Idle-on units may rise after a stop, so they are masked
  a_cken_rise: assert property (
    @(posedge jbus_clk) disable iff (rst)
    ((cken & ~$past(cken) & ~cken_default_on) != '0) |-> $past(start_clk)
  ) else begin
    fail_cnt++;
    $error("cken bit rose while start_clk was low");
  end

endmodule

// Attach to every instance of the top
bind ctu_clsp_top ctu_clsp_assert u_assert (
  .jbus_clk    (jbus_clk),
  .rst         (rst),
  .start_clk   (start_clk),
  .cken        (cken),
  .trig_event  (trig_event)
);

/* verif/tb_ctu_clsp.sv */
// Table-driven testbench for the clock-enable sequencer top; run via files.f and the Makefile
module tb_ctu_clsp
  import ctu_cken_pkg::*,
         ctu_trig_pkg::*;
;

  localparam int unsigned stagger   = 4;   // Same value as the DUT
  localparam int unsigned rst_cyc   = 16;
  localparam int unsigned all_on_n  = (num_unit - 1) * stagger + 3;  // Edges after start

  typedef enum logic [2:0] {
    act_none,
    act_start,
    act_stop,
    act_trig,      // New trigger level
    act_clr,       // Clear pulse alone
    act_clr_rise   // Trigger change, then clear on the edge its rise lands
  } act_e;

  typedef struct {
    act_e        act;
    trig_vec_t   pat;         // Trigger level for trig steps
    int unsigned wait_cyc;    // Edges before the final check
    cken_vec_t   exp_cken;
    logic        exp_all_on;
    trig_vec_t   exp_jl;
    trig_vec_t   exp_status;
    logic        exp_event;   // Pulse expected on the second edge
  } step_t;

  logic      jbus_clk;
  logic      rst;
  logic      start;
  logic      stop;
  trig_vec_t trig;
  logic      trig_clr;
  cken_vec_t cken;
  logic      cken_all_on;
  trig_vec_t trig_jl;
  logic      trig_event;
  trig_vec_t trig_status;

  step_t       steps[$];
  int unsigned err_cnt;
  int unsigned check_cnt;
  int unsigned wd_cycles = 0;  // Zero until the table is built
  logic [31:0] rng;

  // Model state while the table is built
  logic        m_started;
  int unsigned m_n;       // Edges since the start was sampled
  trig_vec_t   m_trig;
  trig_vec_t   m_status;
  int unsigned tot_wait;

  ctu_clsp_top #(
    .stagger     (stagger)
  ) DUT (
    .jbus_clk    (jbus_clk),
    .rst         (rst),
    .start       (start),
    .stop        (stop),
    .trig        (trig),
    .trig_clr    (trig_clr),
    .cken        (cken),
    .cken_all_on (cken_all_on),
    .trig_jl     (trig_jl),
    .trig_event  (trig_event),
    .trig_status (trig_status)
  );

  initial begin
    jbus_clk = 1'b0;
    forever #4 jbus_clk = ~jbus_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic trig_vec_t rand_pattern();
    rng = xorshift32(rng);
    return rng[num_trig-1:0];
  endfunction

  // Unit k is on once n reaches k * stagger + 2, before that it is off
  function automatic cken_vec_t cken_at(input int unsigned n);
    cken_vec_t v;
    if (n == 0) begin
      return cken_default_on;  // Start just sampled, slices still idle
    end
    for (int unsigned k = 0; k < num_unit; k++) begin
      v[k] = (n >= k * stagger + 2);
    end
    return v;
  endfunction

  function automatic void add_step(input act_e act, input trig_vec_t pat,
                                   input int unsigned wait_cyc);
    step_t     s;
    trig_vec_t rise;
    rise = '0;
    case (act)
      act_start: begin
        if (!m_started) begin
          m_started = 1'b1;
          m_n       = wait_cyc - 1;
        end else begin
          m_n += wait_cyc;  // Repeat start ignored
        end
      end
      act_stop: m_started = 1'b0;
      act_trig: begin
        rise     = pat & ~m_trig;
        m_trig   = pat;
        m_status = m_status | rise;
      end
      act_clr: m_status = '0;
      act_clr_rise: begin
        rise     = pat & ~m_trig;
        m_trig   = pat;
        m_status = rise;  // Same-edge set beats the clear
      end
      default: ;
    endcase
    if (act != act_start && m_started) begin
      m_n += wait_cyc;
    end
    s.act        = act;
    s.pat        = pat;
    s.wait_cyc   = wait_cyc;
    s.exp_cken   = m_started ? cken_at(m_n) : cken_default_on;
    s.exp_all_on = m_started && (m_n >= all_on_n);
    s.exp_jl     = m_trig;
    s.exp_status = m_status;
    s.exp_event  = (rise != '0);
    tot_wait += wait_cyc;
    steps.push_back(s);
  endfunction

  task automatic build_table();
    m_started = 1'b0;
    m_n       = 0;
    m_trig    = '0;
    m_status  = '0;
    tot_wait  = 0;
    add_step(act_none, '0, 4);        // Idle after reset
    add_step(act_start, '0, 3);       // Unit 0 just on
    for (int unsigned k = 1; k < num_unit; k++) begin
      add_step(act_none, '0, stagger - 1);  // One edge before unit k
      add_step(act_none, '0, 1);            // Unit k turns on
    end
    add_step(act_none, '0, 1);        // All-on flag follows
    add_step(act_start, '0, 4);       // Already started
    repeat (6) add_step(act_trig, rand_pattern(), 3);
    add_step(act_clr, '0, 3);
    repeat (3) add_step(act_trig, rand_pattern(), 3);
    add_step(act_trig, '0, 3);
    add_step(act_clr_rise, rand_pattern() | trig_vec_t'(1), 4);
    add_step(act_stop, '0, 3);
    add_step(act_start, '0, 14);      // Stop lands mid-sequence
    add_step(act_stop, '0, 3);
    repeat (3) add_step(act_trig, rand_pattern(), 3);
    add_step(act_clr, '0, 3);
  endtask

  task automatic tick();
    @(posedge jbus_clk);
    #1;  // Drive and sample just past the edge
  endtask

  task automatic check_cken(input cken_vec_t got, input cken_vec_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t: cken is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_trig(input string what, input trig_vec_t got, input trig_vec_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic run_step(input step_t s, input int idx);
    int unsigned errs_before;
    errs_before = err_cnt;
    case (s.act)
      act_start:    start = 1'b1;
      act_stop:     stop = 1'b1;
      act_trig:     trig = s.pat;
      act_clr:      trig_clr = 1'b1;
      act_clr_rise: trig = s.pat;  // Clear follows one edge later
      default: ;
    endcase
    for (int unsigned i = 1; i <= s.wait_cyc; i++) begin
      tick();
      start = 1'b0;
      stop  = 1'b0;
      trig_clr = (s.act == act_clr_rise) && (i == 1);
      check_bit("trig_event", trig_event, s.exp_event && (i == 2));
    end
    check_cken(cken, s.exp_cken);
    check_bit("cken_all_on", cken_all_on, s.exp_all_on);
    check_trig("trig_jl", trig_jl, s.exp_jl);
    check_trig("trig_status", trig_status, s.exp_status);
    $display("step %0d %s wait %0d: %s", idx, s.act.name(), s.wait_cyc,
             (err_cnt == errs_before) ? "ok" : "error");
  endtask

  // Watchdog, armed once the table length is known
  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge jbus_clk);
    $display("Timeout: run did not finish within %0d cycles", wd_cycles);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    rst       = 1'b1;
    start     = 1'b0;
    stop      = 1'b0;
    trig      = '0;
    trig_clr  = 1'b0;
    err_cnt   = 0;
    check_cnt = 0;
    rng       = 32'd69;
    build_table();
    wd_cycles = rst_cyc + tot_wait + 64;  // Margin for reset release and wrap-up
    repeat (rst_cyc) @(posedge jbus_clk);
    #1 rst = 1'b0;
    foreach (steps[i]) begin
      run_step(steps[i], i);
    end
    err_cnt += DUT.u_assert.fail_cnt;  // Bound assertion failures
    $display("Steps %0d, checks %0d, errors %0d, assertion failures %0d",
             steps.size(), check_cnt, err_cnt, DUT.u_assert.fail_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
hdl/ctu_cken_pkg.sv
hdl/ctu_trig_pkg.sv
hdl/ctu_cken_seq.sv
hdl/ctu_cken_sync_slice.sv
hdl/ctu_trig_collect.sv
hdl/ctu_clsp_top.sv
verif/ctu_clsp_assert.sv
verif/tb_ctu_clsp.sv

/* Makefile */
# Verilator build and run of the clock-enable sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_ctu_clsp
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
